//--- logic/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;

    // alu function
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_AND   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_XOR   = 4'd4,
        ALU_SLL   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_SLT   = 4'd8,
        ALU_SLTU  = 4'd9,
        ALU_JALR  = 4'd10, // add, then clear bit 0
        ALU_PASS2 = 4'd11
    } alu_op_e;

    // branch condition, rs1 against rs2
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4,
        BR_LTU  = 3'd5,
        BR_GEU  = 3'd6
    } br_op_e;

    typedef enum logic [1:0] {
        OP1_RS1  = 2'd0,
        OP1_PC   = 2'd1,
        OP1_ZERO = 2'd2
    } op1_sel_e;

    typedef enum logic [2:0] {
        OP2_RS2   = 3'd0,
        OP2_IMM_I = 3'd1,
        OP2_IMM_S = 3'd2,
        OP2_IMM_J = 3'd3,
        OP2_IMM_U = 3'd4
    } op2_sel_e;

    typedef enum logic [1:0] {
        WB_ALU     = 2'd0,
        WB_MEM     = 2'd1,
        WB_PC_LINK = 2'd2  // pc + 4
    } wb_sel_e;

    // major opcodes, inst[6:0]
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    localparam reg_addr_t GP_REG = 5'd3; // x3, brought out as gp

endpackage

//--- logic/core_ctrl.sv
`timescale 1ns/1ps

module core_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic is_load_i,
    input  logic is_store_i,
    input  logic rf_wen_i,
    output logic pc_we_o,
    output logic rf_we_o,
    output logic dmem_we_o
);

    typedef enum logic [1:0] {
        FETCH    = 2'd0,
        EXEC     = 2'd1,
        MEM_WAIT = 2'd2
    } state_e;

    state_e state;
    state_e state_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= FETCH;
        end else begin
            state <= state_next;
        end
    end

    // strobes come straight from the state
    always_comb begin
        state_next = state;
        pc_we_o    = 1'b0;
        rf_we_o    = 1'b0;
        dmem_we_o  = 1'b0;
        case (state)
            FETCH: state_next = EXEC; // imem read in flight
            EXEC: begin
                if (is_load_i) begin
                    state_next = MEM_WAIT; // dmem data valid next cycle
                end else begin
                    state_next = FETCH;
                    pc_we_o    = 1'b1;
                    rf_we_o    = rf_wen_i;
                    dmem_we_o  = is_store_i;
                end
            end
            MEM_WAIT: begin
                state_next = FETCH;
                pc_we_o    = 1'b1;
                rf_we_o    = rf_wen_i;
            end
            default: state_next = FETCH;
        endcase
    end

endmodule

//--- logic/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
    parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          pc_we_i,
    input  logic          br_taken_i,
    input  logic          jump_i,
    input  rv_pkg::word_t imm_b_i,
    input  rv_pkg::word_t alu_result_i,
    output rv_pkg::word_t pc_o,
    output rv_pkg::word_t imem_addr_o
);

    rv_pkg::word_t pc;
    rv_pkg::word_t pc_next;

    always_comb begin
        if (br_taken_i) begin
            pc_next = pc + imm_b_i;
        end else if (jump_i) begin
            pc_next = alu_result_i; // jal / jalr target from the alu
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (pc_we_i) begin
            pc <= pc_next;
        end
    end

    // address held for the whole instruction
    assign imem_addr_o = pc;
    assign pc_o        = pc;

endmodule

//--- logic/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  rv_pkg::inst_t     inst_i,
    output rv_pkg::reg_addr_t rs1_o,
    output rv_pkg::reg_addr_t rs2_o,
    output rv_pkg::reg_addr_t rd_o,
    output rv_pkg::word_t     imm_o,
    output rv_pkg::word_t     imm_b_o,
    output rv_pkg::alu_op_e   alu_op_o,
    output rv_pkg::br_op_e    br_op_o,
    output rv_pkg::op1_sel_e  op1_sel_o,
    output rv_pkg::op2_sel_e  op2_sel_o,
    output rv_pkg::wb_sel_e   wb_sel_o,
    output logic              rf_wen_o,
    output logic              is_load_o,
    output logic              is_store_o,
    output logic              jump_o
);

    logic [6:0]    opcode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    rv_pkg::word_t imm_i;
    rv_pkg::word_t imm_s;
    rv_pkg::word_t imm_j;
    rv_pkg::word_t imm_u;
    logic          shift_ok; // funct7 legal for this funct3

    // shared by op and op-imm, alt is inst[30]
    function automatic rv_pkg::alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  f3_to_alu = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  f3_to_alu = rv_pkg::ALU_SLL;
            3'b010:  f3_to_alu = rv_pkg::ALU_SLT;
            3'b011:  f3_to_alu = rv_pkg::ALU_SLTU;
            3'b100:  f3_to_alu = rv_pkg::ALU_XOR;
            3'b101:  f3_to_alu = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  f3_to_alu = rv_pkg::ALU_OR;
            default: f3_to_alu = rv_pkg::ALU_AND;
        endcase
    endfunction

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rs1_o  = inst_i[19:15];
    assign rs2_o  = inst_i[24:20];
    assign rd_o   = inst_i[11:7];

    assign imm_i   = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s   = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b_o = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j   = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign imm_u   = {inst_i[31:12], 12'd0};

    assign shift_ok = (funct7 == 7'b0000000) || (funct7 == 7'b0100000 && funct3 == 3'b101);

    always_comb begin
        // anything unrecognised falls through as a no-op
        alu_op_o   = rv_pkg::ALU_ADD;
        br_op_o    = rv_pkg::BR_NONE;
        op1_sel_o  = rv_pkg::OP1_RS1;
        op2_sel_o  = rv_pkg::OP2_RS2;
        wb_sel_o   = rv_pkg::WB_ALU;
        rf_wen_o   = 1'b0;
        is_load_o  = 1'b0;
        is_store_o = 1'b0;
        jump_o     = 1'b0;
        case (opcode)
            rv_pkg::OPC_OP: begin
                if (funct7 == 7'b0000000 || (funct7 == 7'b0100000 && funct3 == 3'b000)
                        || shift_ok) begin
                    alu_op_o = f3_to_alu(funct3, funct7[5]);
                    rf_wen_o = 1'b1;
                end
            end
            rv_pkg::OPC_OP_IMM: begin
                if ((funct3 != 3'b001 && funct3 != 3'b101) || shift_ok) begin
                    alu_op_o  = f3_to_alu(funct3, funct3 == 3'b101 && funct7[5]);
                    op2_sel_o = rv_pkg::OP2_IMM_I;
                    rf_wen_o  = 1'b1;
                end
            end
            rv_pkg::OPC_LOAD: begin
                if (funct3 == 3'b010) begin // lw only
                    op2_sel_o = rv_pkg::OP2_IMM_I;
                    wb_sel_o  = rv_pkg::WB_MEM;
                    rf_wen_o  = 1'b1;
                    is_load_o = 1'b1;
                end
            end
            rv_pkg::OPC_STORE: begin
                if (funct3 == 3'b010) begin
                    op2_sel_o  = rv_pkg::OP2_IMM_S;
                    is_store_o = 1'b1;
                end
            end
            rv_pkg::OPC_BRANCH: begin
                case (funct3)
                    3'b000:  br_op_o = rv_pkg::BR_EQ;
                    3'b001:  br_op_o = rv_pkg::BR_NE;
                    3'b100:  br_op_o = rv_pkg::BR_LT;
                    3'b101:  br_op_o = rv_pkg::BR_GE;
                    3'b110:  br_op_o = rv_pkg::BR_LTU;
                    3'b111:  br_op_o = rv_pkg::BR_GEU;
                    default: br_op_o = rv_pkg::BR_NONE;
                endcase
            end
            rv_pkg::OPC_JAL: begin
                op1_sel_o = rv_pkg::OP1_PC;
                op2_sel_o = rv_pkg::OP2_IMM_J;
                wb_sel_o  = rv_pkg::WB_PC_LINK;
                rf_wen_o  = 1'b1;
                jump_o    = 1'b1;
            end
            rv_pkg::OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    alu_op_o  = rv_pkg::ALU_JALR;
                    op2_sel_o = rv_pkg::OP2_IMM_I;
                    wb_sel_o  = rv_pkg::WB_PC_LINK;
                    rf_wen_o  = 1'b1;
                    jump_o    = 1'b1;
                end
            end
            rv_pkg::OPC_LUI: begin
                alu_op_o  = rv_pkg::ALU_PASS2;
                op1_sel_o = rv_pkg::OP1_ZERO;
                op2_sel_o = rv_pkg::OP2_IMM_U;
                rf_wen_o  = 1'b1;
            end
            rv_pkg::OPC_AUIPC: begin
                op1_sel_o = rv_pkg::OP1_PC;
                op2_sel_o = rv_pkg::OP2_IMM_U;
                rf_wen_o  = 1'b1;
            end
            default: ;
        endcase
    end

    // one immediate goes to the alu, picked by operand select
    always_comb begin
        case (op2_sel_o)
            rv_pkg::OP2_IMM_I: imm_o = imm_i;
            rv_pkg::OP2_IMM_S: imm_o = imm_s;
            rv_pkg::OP2_IMM_J: imm_o = imm_j;
            rv_pkg::OP2_IMM_U: imm_o = imm_u;
            default:           imm_o = '0;
        endcase
    end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t rs1_i,
    input  rv_pkg::reg_addr_t rs2_i,
    input  rv_pkg::reg_addr_t rd_i,
    input  logic              we_i,
    input  rv_pkg::word_t     wdata_i,
    output rv_pkg::word_t     rs1_data_o,
    output rv_pkg::word_t     rs2_data_o,
    output rv_pkg::word_t     gp_o
);

    rv_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != 5'd0) begin // x0 stays zero
            regs[rd_i] <= wdata_i;
        end
    end

    assign rs1_data_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];
    assign gp_o       = regs[rv_pkg::GP_REG];

endmodule

//--- logic/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  rv_pkg::word_t    pc_i,
    input  rv_pkg::word_t    rs1_data_i,
    input  rv_pkg::word_t    rs2_data_i,
    input  rv_pkg::word_t    imm_i,
    input  rv_pkg::alu_op_e  alu_op_i,
    input  rv_pkg::br_op_e   br_op_i,
    input  rv_pkg::op1_sel_e op1_sel_i,
    input  rv_pkg::op2_sel_e op2_sel_i,
    output rv_pkg::word_t    alu_result_o,
    output logic             br_taken_o
);

    rv_pkg::word_t op1;
    rv_pkg::word_t op2;
    logic [4:0]    shamt;

    always_comb begin
        case (op1_sel_i)
            rv_pkg::OP1_PC:   op1 = pc_i;
            rv_pkg::OP1_ZERO: op1 = '0;
            default:          op1 = rs1_data_i;
        endcase
        // every immediate form arrives already extended
        op2 = (op2_sel_i == rv_pkg::OP2_RS2) ? rs2_data_i : imm_i;
    end

    assign shamt = op2[4:0];

    always_comb begin
        case (alu_op_i)
            rv_pkg::ALU_SUB:   alu_result_o = op1 - op2;
            rv_pkg::ALU_AND:   alu_result_o = op1 & op2;
            rv_pkg::ALU_OR:    alu_result_o = op1 | op2;
            rv_pkg::ALU_XOR:   alu_result_o = op1 ^ op2;
            rv_pkg::ALU_SLL:   alu_result_o = op1 << shamt;
            rv_pkg::ALU_SRL:   alu_result_o = op1 >> shamt;
            rv_pkg::ALU_SRA:   alu_result_o = $signed(op1) >>> shamt;
            rv_pkg::ALU_SLT:   alu_result_o = {31'd0, $signed(op1) < $signed(op2)};
            rv_pkg::ALU_SLTU:  alu_result_o = {31'd0, op1 < op2};
            rv_pkg::ALU_JALR:  alu_result_o = (op1 + op2) & ~32'd1;
            rv_pkg::ALU_PASS2: alu_result_o = op2;
            default:           alu_result_o = op1 + op2;
        endcase
    end

    // compares the registers directly, not the alu operands
    always_comb begin
        case (br_op_i)
            rv_pkg::BR_EQ:  br_taken_o = rs1_data_i == rs2_data_i;
            rv_pkg::BR_NE:  br_taken_o = rs1_data_i != rs2_data_i;
            rv_pkg::BR_LT:  br_taken_o = $signed(rs1_data_i) < $signed(rs2_data_i);
            rv_pkg::BR_GE:  br_taken_o = $signed(rs1_data_i) >= $signed(rs2_data_i);
            rv_pkg::BR_LTU: br_taken_o = rs1_data_i < rs2_data_i;
            rv_pkg::BR_GEU: br_taken_o = rs1_data_i >= rs2_data_i;
            default:        br_taken_o = 1'b0;
        endcase
    end

endmodule

//--- logic/mem_wb_unit.sv
`timescale 1ns/1ps

module mem_wb_unit (
    input  rv_pkg::word_t   pc_i,
    input  rv_pkg::word_t   alu_result_i,
    input  rv_pkg::word_t   rs2_data_i,
    input  rv_pkg::word_t   dmem_rdata_i,
    input  rv_pkg::wb_sel_e wb_sel_i,
    output rv_pkg::word_t   dmem_addr_o,
    output rv_pkg::word_t   dmem_wdata_o,
    output rv_pkg::word_t   wb_data_o
);

    rv_pkg::word_t link_addr;

    // effective address is rs1 + imm from the alu
    assign dmem_addr_o  = alu_result_i;
    assign dmem_wdata_o = rs2_data_i; // full word, no byte lanes
    assign link_addr    = pc_i + 32'd4;

    always_comb begin
        case (wb_sel_i)
            rv_pkg::WB_MEM:     wb_data_o = dmem_rdata_i; // valid in mem_wait
            rv_pkg::WB_PC_LINK: wb_data_o = link_addr;
            default:            wb_data_o = alu_result_i;
        endcase
    end

endmodule

//--- logic/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
    parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          rst_n,
    output rv_pkg::word_t imem_addr_o,
    input  rv_pkg::inst_t imem_rdata_i,
    output rv_pkg::word_t dmem_addr_o,
    output rv_pkg::word_t dmem_wdata_o,
    output logic          dmem_we_o,
    input  rv_pkg::word_t dmem_rdata_i,
    output rv_pkg::word_t gp_o
);

    rv_pkg::word_t     pc;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    rv_pkg::reg_addr_t rd;
    rv_pkg::word_t     imm;
    rv_pkg::word_t     imm_b;
    rv_pkg::alu_op_e   alu_op;
    rv_pkg::br_op_e    br_op;
    rv_pkg::op1_sel_e  op1_sel;
    rv_pkg::op2_sel_e  op2_sel;
    rv_pkg::wb_sel_e   wb_sel;
    logic              rf_wen;
    logic              is_load;
    logic              is_store;
    logic              jump;
    logic              pc_we;
    logic              rf_we;
    rv_pkg::word_t     rs1_data;
    rv_pkg::word_t     rs2_data;
    rv_pkg::word_t     alu_result;
    logic              br_taken;
    rv_pkg::word_t     wb_data;

    core_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .is_load_i  (is_load),
        .is_store_i (is_store),
        .rf_wen_i   (rf_wen),
        .pc_we_o    (pc_we),
        .rf_we_o    (rf_we),
        .dmem_we_o  (dmem_we_o)
    );

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc_we_i      (pc_we),
        .br_taken_i   (br_taken),
        .jump_i       (jump),
        .imm_b_i      (imm_b),
        .alu_result_i (alu_result),
        .pc_o         (pc),
        .imem_addr_o  (imem_addr_o)
    );

    inst_decoder u_dec (
        .inst_i     (imem_rdata_i),
        .rs1_o      (rs1),
        .rs2_o      (rs2),
        .rd_o       (rd),
        .imm_o      (imm),
        .imm_b_o    (imm_b),
        .alu_op_o   (alu_op),
        .br_op_o    (br_op),
        .op1_sel_o  (op1_sel),
        .op2_sel_o  (op2_sel),
        .wb_sel_o   (wb_sel),
        .rf_wen_o   (rf_wen),
        .is_load_o  (is_load),
        .is_store_o (is_store),
        .jump_o     (jump)
    );

    reg_file u_rf (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rd_i       (rd),
        .we_i       (rf_we),
        .wdata_i    (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .gp_o       (gp_o)
    );

    exec_unit u_exec (
        .pc_i         (pc),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .imm_i        (imm),
        .alu_op_i     (alu_op),
        .br_op_i      (br_op),
        .op1_sel_i    (op1_sel),
        .op2_sel_i    (op2_sel),
        .alu_result_o (alu_result),
        .br_taken_o   (br_taken)
    );

    mem_wb_unit u_mem_wb (
        .pc_i         (pc),
        .alu_result_i (alu_result),
        .rs2_data_i   (rs2_data),
        .dmem_rdata_i (dmem_rdata_i),
        .wb_sel_i     (wb_sel),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .wb_data_o    (wb_data)
    );

endmodule

//--- dv/rv_core_props.sv
`timescale 1ns/1ps

module rv_core_props (
    input logic clk,
    input logic rst_n,
    input logic pc_we_i,
    input logic rf_we_i,
    input logic dmem_we_i
);

    // a store never writes a register
    a_we_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(dmem_we_i && rf_we_i))
        else $error("dmem write and register write strobes high together");

    // every instruction takes at least two cycles
    a_pc_we_gap: assert property (@(posedge clk) disable iff (!rst_n)
        pc_we_i |=> !pc_we_i)
        else $error("pc write strobe high in two consecutive cycles");

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |=> !(pc_we_i || rf_we_i || dmem_we_i))
        else $error("write strobe high in the cycle after reset");

endmodule

bind core_ctrl rv_core_props u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .pc_we_i   (pc_we_o),
    .rf_we_i   (rf_we_o),
    .dmem_we_i (dmem_we_o)
);

//--- dv/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

    logic          clk;
    logic          rst_n;
    rv_pkg::word_t imem_addr;
    rv_pkg::inst_t imem_rdata;
    rv_pkg::word_t dmem_addr;
    rv_pkg::word_t dmem_wdata;
    logic          dmem_we;
    rv_pkg::word_t dmem_rdata;
    rv_pkg::word_t gp;

    rv_pkg::inst_t imem [256];
    rv_pkg::word_t dmem [512];
    rv_pkg::inst_t prog [$];
    rv_pkg::word_t exp_addr [$];
    rv_pkg::word_t exp_data [$];
    rv_pkg::word_t st_addr [$]; // observed stores, in order
    rv_pkg::word_t st_data [$];
    rv_pkg::word_t iaddr_q;
    rv_pkg::word_t daddr_q;
    rv_pkg::word_t halt_pc;
    integer        seed;
    int            cycles = 0;
    int            limit = 200; // grows by 3 cycles per loaded instruction

    rv_core UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_rdata_i (imem_rdata),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_we_o    (dmem_we),
        .dmem_rdata_i (dmem_rdata),
        .gp_o         (gp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // both memories synchronous, read data lands 1 ns after the edge
    always @(posedge clk) begin
        iaddr_q = imem_addr;
        daddr_q = dmem_addr;
        if (dmem_we === 1'b1) begin
            dmem[daddr_q[10:2]] = dmem_wdata;
            st_addr.push_back(daddr_q);
            st_data.push_back(dmem_wdata);
        end
        #1;
        imem_rdata = imem[iaddr_q[9:2]];
        dmem_rdata = dmem[daddr_q[10:2]];
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: the core did not reach its halt loop after %0d cycles", cycles);
            $display("=== FAIL ===");
            $fatal(1);
        end
    end

    task automatic check_word(input string name, input rv_pkg::word_t got,
                              input rv_pkg::word_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    function automatic rv_pkg::inst_t r_form(input logic [6:0] f7, input rv_pkg::reg_addr_t rs2,
            input rv_pkg::reg_addr_t rs1, input logic [2:0] f3, input rv_pkg::reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
    endfunction

    function automatic rv_pkg::inst_t i_form(input rv_pkg::word_t imm, input rv_pkg::reg_addr_t rs1,
            input logic [2:0] f3, input rv_pkg::reg_addr_t rd, input logic [6:0] opc);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic rv_pkg::inst_t s_form(input rv_pkg::word_t imm, input rv_pkg::reg_addr_t rs2,
            input rv_pkg::reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OPC_STORE};
    endfunction

    function automatic rv_pkg::inst_t b_form(input rv_pkg::word_t imm, input rv_pkg::reg_addr_t rs2,
            input rv_pkg::reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OPC_BRANCH};
    endfunction

    function automatic rv_pkg::inst_t u_form(input rv_pkg::word_t val, input rv_pkg::reg_addr_t rd,
            input logic [6:0] opc);
        return {val[31:12], rd, opc};
    endfunction

    function automatic rv_pkg::inst_t j_form(input rv_pkg::word_t imm, input rv_pkg::reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OPC_JAL};
    endfunction

    // RV32I results, b is rs2 or the sign-extended immediate
    function automatic rv_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
            input rv_pkg::word_t a, input rv_pkg::word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? rv_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input rv_pkg::word_t a,
            input rv_pkg::word_t b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic rv_pkg::word_t fill_word(input int idx);
        return (idx * 32'h9e37_79b9) ^ 32'h5a5a_5a5a;
    endfunction

    task automatic emit(input rv_pkg::inst_t inst);
        prog.push_back(inst);
    endtask

    // lui + addi, upper part rounded for the signed low half
    task automatic load_imm(input rv_pkg::reg_addr_t rd, input rv_pkg::word_t val);
        emit(u_form(val + 32'h800, rd, rv_pkg::OPC_LUI));
        emit(i_form(val, rd, 3'b000, rd, rv_pkg::OPC_OP_IMM));
    endtask

    task automatic store_reg(input rv_pkg::reg_addr_t rs, input rv_pkg::word_t addr,
                             input rv_pkg::word_t exp);
        emit(s_form(addr, rs, 5'd0));
        exp_addr.push_back(addr);
        exp_data.push_back(exp);
    endtask

    task automatic new_program;
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic start_reset;
        @(posedge clk);
        #1 rst_n = 1'b0;
        repeat (7) @(posedge clk);
    endtask

    task automatic release_reset;
        @(posedge clk);
        #1 rst_n = 1'b1;
    endtask

    // loads under reset, runs to the jal-to-self, then checks every store
    task automatic run_program;
        emit(j_form(32'd0, 5'd0));
        halt_pc = 32'(4 * (prog.size() - 1));
        limit = limit + 3 * prog.size();
        start_reset;
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : '0;
        end
        for (int i = 0; i < 512; i++) begin
            dmem[i] = fill_word(i);
        end
        st_addr.delete();
        st_data.delete();
        release_reset;
        @(negedge clk);
        while (imem_addr !== halt_pc) @(negedge clk);
        check_word("store count", st_addr.size(), exp_addr.size());
        for (int i = 0; i < exp_addr.size(); i++) begin
            check_word($sformatf("store %0d address", i), st_addr[i], exp_addr[i]);
            check_word($sformatf("store %0d data", i), st_data[i], exp_data[i]);
        end
    endtask

    task automatic test_alu;
        logic [2:0]    r_f3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
        logic          r_alt [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
        logic [2:0]    i_f3 [9] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
        logic          i_alt [9] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        rv_pkg::word_t imm;
        rv_pkg::word_t addr;
        new_program;
        a = $random(seed);
        b = $random(seed);
        addr = 32'h200;
        load_imm(5'd1, a);
        load_imm(5'd2, b);
        for (int k = 0; k < 10; k++) begin
            emit(r_form(r_alt[k] ? 7'h20 : 7'h00, 5'd2, 5'd1, r_f3[k], 5'd5));
            store_reg(5'd5, addr, alu_ref(r_f3[k], r_alt[k], a, b));
            addr = addr + 32'd4;
        end
        for (int k = 0; k < 9; k++) begin
            imm = $random(seed);
            if (i_f3[k] == 3'd1 || i_f3[k] == 3'd5) begin
                imm = {20'd0, i_alt[k] ? 7'h20 : 7'h00, imm[4:0]};
            end
            imm = {{20{imm[11]}}, imm[11:0]};
            emit(i_form(imm, 5'd1, i_f3[k], 5'd5, rv_pkg::OPC_OP_IMM));
            store_reg(5'd5, addr, alu_ref(i_f3[k], i_alt[k], a, imm));
            addr = addr + 32'd4;
        end
        run_program;
    endtask

    task automatic test_load_store;
        rv_pkg::word_t v;
        new_program;
        v = $random(seed);
        load_imm(5'd1, v);
        store_reg(5'd1, 32'h300, v);
        emit(i_form(32'h300, 5'd0, 3'b010, 5'd2, rv_pkg::OPC_LOAD));
        emit(i_form(32'd1, 5'd2, 3'b000, 5'd2, rv_pkg::OPC_OP_IMM));
        store_reg(5'd2, 32'h304, v + 32'd1);
        emit(i_form(32'h340, 5'd0, 3'b010, 5'd3, rv_pkg::OPC_LOAD)); // untouched word
        store_reg(5'd3, 32'h308, fill_word(32'h340 >> 2));
        run_program;
    endtask

    task automatic test_branches;
        logic [2:0]    br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        rv_pkg::word_t tmp;
        int            n;
        new_program;
        n = 0;
        for (int k = 0; k < 6; k++) begin
            for (int want = 1; want >= 0; want--) begin
                a = $random(seed);
                b = $random(seed);
                if (branch_ref(br_f3[k], a, b) != want) begin
                    if (branch_ref(br_f3[k], b, a) == want) begin
                        tmp = a;
                        a = b;
                        b = tmp;
                    end else begin
                        b = a;
                    end
                end
                load_imm(5'd1, a);
                load_imm(5'd2, b);
                emit(b_form(32'd12, 5'd2, 5'd1, br_f3[k]));
                emit(i_form(32'h80 + n, 5'd0, 3'b000, 5'd4, rv_pkg::OPC_OP_IMM));
                emit(j_form(32'd8, 5'd0)); // over the taken marker
                emit(i_form(32'h40 + n, 5'd0, 3'b000, 5'd4, rv_pkg::OPC_OP_IMM));
                store_reg(5'd4, 32'h400 + 4 * n, want ? 32'h40 + n : 32'h80 + n);
                n++;
            end
        end
        run_program;
    endtask

    // program starts at 0, so link and auipc values follow from the slot
    task automatic test_jumps;
        new_program;
        emit(j_form(32'd8, 5'd1));
        emit(i_form(32'h7ff, 5'd0, 3'b000, 5'd5, rv_pkg::OPC_OP_IMM)); // skipped
        store_reg(5'd1, 32'h500, 32'd4);
        emit(u_form(32'h1234_5000, 5'd6, rv_pkg::OPC_AUIPC));
        store_reg(5'd6, 32'h504, 32'h1234_500c);
        emit(u_form(32'habcd_e000, 5'd7, rv_pkg::OPC_LUI));
        store_reg(5'd7, 32'h508, 32'habcd_e000);
        emit(i_form(32'd45, 5'd0, 3'b000, 5'd8, rv_pkg::OPC_OP_IMM));
        emit(i_form(32'd0, 5'd8, 3'b000, 5'd9, rv_pkg::OPC_JALR)); // lands on 44
        emit(i_form(32'd1, 5'd0, 3'b000, 5'd5, rv_pkg::OPC_OP_IMM));
        emit(i_form(32'd2, 5'd0, 3'b000, 5'd5, rv_pkg::OPC_OP_IMM));
        store_reg(5'd9, 32'h50c, 32'd36);
        store_reg(5'd5, 32'h510, 32'd0);
        run_program;
    endtask

    task automatic test_gp_x0;
        rv_pkg::word_t v;
        new_program;
        v = $random(seed);
        load_imm(rv_pkg::GP_REG, v);
        emit(i_form(32'd5, rv_pkg::GP_REG, 3'b000, rv_pkg::GP_REG, rv_pkg::OPC_OP_IMM));
        emit(i_form(32'h123, rv_pkg::GP_REG, 3'b000, 5'd0, rv_pkg::OPC_OP_IMM));
        store_reg(5'd0, 32'h600, 32'd0);
        run_program;
        check_word("gp_o", gp, v + 32'd5);
    endtask

    task automatic test_reset;
        imem[0] = s_form(32'h700, 5'd0, 5'd0); // store decoded at the reset pc
        start_reset;
        @(negedge clk);
        check_bit("dmem_we_o", dmem_we, 1'b0);
        release_reset;
        @(negedge clk);
        check_word("imem_addr_o", imem_addr, 32'h0000_0000);
        check_bit("dmem_we_o", dmem_we, 1'b0);
        check_word("gp_o", gp, 32'd0);
    endtask

    initial begin
        seed = 32'h605c_35e6;
        rst_n = 1'b0;
        imem_rdata = '0;
        dmem_rdata = '0;
        test_alu;
        test_load_store;
        test_branches;
        test_jumps;
        test_gp_x0;
        test_reset; // after gp was written
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- files.f
logic/rv_pkg.sv
logic/core_ctrl.sv
logic/fetch_unit.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/mem_wb_unit.sv
logic/rv_core.sv
dv/rv_core_props.sv
dv/rv_core_tb.sv
